// File: bench/merge_props.sv
/*
 * Protocol properties on the merged memory port.
 * Bound into axi_port_merge by the bind statement below.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module merge_props (
    input logic                          clk_i,
    input logic                          reset_i,
    input logic                          m_ar_valid_o,
    input logic                          m_ar_ready_i,
    input logic [`MERGE_ID_W-1:0]        m_ar_id_o,
    input logic [`MERGE_ADDR_W-1:0]      m_ar_addr_o,
    input logic                          m_aw_valid_o,
    input logic                          m_aw_ready_i,
    input logic [`MERGE_ID_W-1:0]        m_aw_id_o,
    input logic [`MERGE_ADDR_W-1:0]      m_aw_addr_o,
    input logic                          m_w_valid_o,
    input logic [`MERGE_N_SRC-1:0]       src_w_ready_o
);

    // stalled request keeps its fields
    ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_id_o)
            && $stable(m_ar_addr_o))
        else $error("AR request changed while stalled");

    aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_id_o)
            && $stable(m_aw_addr_o))
        else $error("AW request changed while stalled");

    w_ready_gated: assert property (@(posedge clk_i) disable iff (reset_i)
        !m_w_valid_o |-> src_w_ready_o == '0)
        else $error("master w_ready high without a W beat on the port");

endmodule

bind axi_port_merge merge_props props_inst (.*);

// File: bench/merge_trace.txt
// per step two words, stimulus then expected, one nibble per column
// stim: ar_vld aw_vld w_vld w_last mem_rdy(ar,aw,w) rb_vld(r,b) r_id b_id r_rdy b_rdy
// exp : m_vld(ar,aw,w) ar_src aw_src w_src ar_rdy aw_rdy w_rdy r_vld b_vld m_rb_rdy
0000700000 0fff000000 // reset idle
7000700000 10ff100000 // round-robin 0,1,2,0
7000700000 11ff200000
7000700000 12ff400000
7000700000 10ff100000
4000700000 12ff400000 // lone requesters
2000700000 11ff200000
0700500000 2f0f000000 // AW back-pressure, grant locked to 0
0700500000 2f0f000000
0700500000 2f0f000000
0711700000 2f0f010000 // handshake, no W beat yet
0011700000 4ff0001000
0600700000 2f1f020000 // write order, bypass then dcache
0460700000 6f21042000
0062700000 4ff1002000
0044700000 4ff2004000
0044700000 0fff000000 // FIFO empty again
0000730010 0fff000111 // response steering
0000739922 0fff000223
000073cc04 0fff000442
0000734440 0fff000441
0000000000 0fff000000

// File: bench/tb_axi_port_merge.sv
/*
 * Trace-driven testbench for the memory-side port merge.
 * Reads bench/merge_trace.txt, drives one step per clock and checks
 * the merged port and the per-master handshakes against the trace.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module tb_axi_port_merge;

    localparam int N = `MERGE_N_SRC;

    logic clk_i = 1'b0;
    logic reset_i;
    logic [N-1:0] src_ar_valid_i, src_aw_valid_i, src_w_valid_i, src_w_last_i;
    logic [N-1:0][`MERGE_ID_W-1:0]     src_ar_id_i, src_aw_id_i;
    logic [N-1:0][`MERGE_ADDR_W-1:0]   src_ar_addr_i, src_aw_addr_i;
    logic [N-1:0][`MERGE_LEN_W-1:0]    src_ar_len_i, src_aw_len_i;
    logic [N-1:0][`MERGE_DATA_W-1:0]   src_w_data_i;
    logic [N-1:0][`MERGE_DATA_W/8-1:0] src_w_strb_i;
    logic [N-1:0] src_ar_ready_o, src_aw_ready_o, src_w_ready_o;
    logic [N-1:0] src_r_valid_o, src_r_last_o, src_b_valid_o;
    logic [N-1:0] src_r_ready_i, src_b_ready_i;
    logic [N-1:0][`MERGE_ID_W-1:0]     src_r_id_o, src_b_id_o;
    logic [N-1:0][`MERGE_DATA_W-1:0]   src_r_data_o;
    logic [N-1:0][`MERGE_RESP_W-1:0]   src_r_resp_o, src_b_resp_o;
    logic m_ar_valid_o, m_ar_ready_i, m_aw_valid_o, m_aw_ready_i;
    logic m_w_valid_o, m_w_last_o, m_w_ready_i;
    logic [`MERGE_ID_W-1:0]     m_ar_id_o, m_aw_id_o, m_r_id_i, m_b_id_i;
    logic [`MERGE_ADDR_W-1:0]   m_ar_addr_o, m_aw_addr_o;
    logic [`MERGE_LEN_W-1:0]    m_ar_len_o, m_aw_len_o;
    logic [`MERGE_DATA_W-1:0]   m_w_data_o, m_r_data_i;
    logic [`MERGE_DATA_W/8-1:0] m_w_strb_o;
    logic m_r_valid_i, m_r_last_i, m_r_ready_o, m_b_valid_i, m_b_ready_o;
    logic [`MERGE_RESP_W-1:0]   m_r_resp_i, m_b_resp_i;

    logic [39:0] trace_mem [0:63];
    int          n_steps;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    int          error_count = 0;

    axi_port_merge axi_port_merge_inst (.*);

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // fixed per-master request fields
    // --------------------------------------------------
    function automatic logic [3:0] id_of(input logic [1:0] s);
        return (s == 2'd0) ? 4'h0 : (s == 2'd1) ? 4'h9 : 4'hC;
    endfunction

    function automatic logic [31:0] ar_addr_of(input logic [1:0] s);
        return 32'h1000_0040 + 32'(s) * 32'h100;
    endfunction

    function automatic logic [31:0] aw_addr_of(input logic [1:0] s);
        return 32'h2000_0080 + 32'(s) * 32'h100;
    endfunction

    function automatic logic [63:0] w_data_of(input logic [1:0] s);
        return 64'h0123_4567_89ab_cd00 | 64'(s);
    endfunction

    function automatic logic [7:0] strb_of(input logic [1:0] s);
        return 8'hff >> s;
    endfunction

    // step ranges follow the sections of the trace
    function automatic string behavior_of(input int step);
        if (step < 1) begin
            return "reset idle";
        end else if (step < 7) begin
            return "round-robin";
        end else if (step < 12) begin
            return "back-pressure";
        end else if (step < 17) begin
            return "write order";
        end
        return "response steering";
    endfunction

    task automatic report_mismatch(input string what, input int step,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("[ERROR] %s, %s at step %0d: expected %h, actual %h",
                 behavior_of(step), what, step, exp, act);
        error_count++;
        $display("Checks failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_value(input string what, input int step,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else report_mismatch(what, step, exp, act);
    endtask

    task automatic apply_step(input logic [39:0] s);
        src_ar_valid_i = s[38:36];
        src_aw_valid_i = s[34:32];
        src_w_valid_i  = s[30:28];
        src_w_last_i   = s[26:24];
        m_ar_ready_i   = s[20];
        m_aw_ready_i   = s[21];
        m_w_ready_i    = s[22];
        m_r_valid_i    = s[16];
        m_b_valid_i    = s[17];
        m_r_id_i       = s[15:12];
        m_b_id_i       = s[11:8];
        src_r_ready_i  = s[6:4];
        src_b_ready_i  = s[2:0];
    endtask

    // response payload changes every step
    task automatic drive_payload(input int step);
        m_r_data_i = 64'hfeed_0000_0000_0000 | 64'(step);
        m_r_resp_i = 2'(step);
        m_r_last_i = step[0];
        m_b_resp_i = 2'(step + 1);
    endtask

    task automatic check_step(input int step, input logic [39:0] stim, input logic [39:0] e);
        check_value("m_valid", step, 64'(e[38:36]),
                    64'({m_w_valid_o, m_aw_valid_o, m_ar_valid_o}));
        if (e[36]) begin
            check_value("m_ar_id", step, 64'(id_of(e[33:32])), 64'(m_ar_id_o));
            check_value("m_ar_addr", step, 64'(ar_addr_of(e[33:32])), 64'(m_ar_addr_o));
            check_value("m_ar_len", step, 64'(e[33:32]), 64'(m_ar_len_o));  // len is the index
        end
        if (e[37]) begin
            check_value("m_aw_id", step, 64'(id_of(e[29:28])), 64'(m_aw_id_o));
            check_value("m_aw_addr", step, 64'(aw_addr_of(e[29:28])), 64'(m_aw_addr_o));
            check_value("m_aw_len", step, 64'(e[29:28]) + 64'd1, 64'(m_aw_len_o));
        end
        if (e[38]) begin
            check_value("m_w_data", step, w_data_of(e[25:24]), m_w_data_o);
            check_value("m_w_strb", step, 64'(strb_of(e[25:24])), 64'(m_w_strb_o));
            check_value("m_w_last", step, 64'(stim[24 + e[25:24]]), 64'(m_w_last_o));
        end
        check_value("src_ar_ready", step, 64'(e[22:20]), 64'(src_ar_ready_o));
        check_value("src_aw_ready", step, 64'(e[18:16]), 64'(src_aw_ready_o));
        check_value("src_w_ready", step, 64'(e[14:12]), 64'(src_w_ready_o));
        check_value("src_r_valid", step, 64'(e[10:8]), 64'(src_r_valid_o));
        check_value("src_b_valid", step, 64'(e[6:4]), 64'(src_b_valid_o));
        check_value("m_r_b_ready", step, 64'(e[1:0]), 64'({m_b_ready_o, m_r_ready_o}));
        // R and B payload reaches every master unchanged
        for (int k = 0; k < N; k++) begin
            check_value("src_r_id", step, 64'(m_r_id_i), 64'(src_r_id_o[k]));
            check_value("src_r_data", step, m_r_data_i, src_r_data_o[k]);
            check_value("src_r_resp", step, 64'(m_r_resp_i), 64'(src_r_resp_o[k]));
            check_value("src_r_last", step, 64'(m_r_last_i), 64'(src_r_last_o[k]));
            check_value("src_b_id", step, 64'(m_b_id_i), 64'(src_b_id_o[k]));
            check_value("src_b_resp", step, 64'(m_b_resp_i), 64'(src_b_resp_o[k]));
        end
    endtask

    // --------------------------------------------------
    // run limit
    // --------------------------------------------------
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: trace did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset_i = 1'b1;
        apply_step('0);
        drive_payload(0);
        for (int s = 0; s < N; s++) begin
            src_ar_id_i[s]   = id_of(2'(s));
            src_aw_id_i[s]   = id_of(2'(s));
            src_ar_addr_i[s] = ar_addr_of(2'(s));
            src_aw_addr_i[s] = aw_addr_of(2'(s));
            src_ar_len_i[s]  = 8'(s);
            src_aw_len_i[s]  = 8'(s + 1);
            src_w_data_i[s]  = w_data_of(2'(s));
            src_w_strb_i[s]  = strb_of(2'(s));
        end

        // unread words keep an ff top byte, no trace column reaches it
        for (int k = 0; k < 64; k++) begin
            trace_mem[k] = {8'hff, 32'(k)};
        end
        $readmemh("bench/merge_trace.txt", trace_mem);
        n_steps = 0;
        while (n_steps < 32 && trace_mem[2 * n_steps][39:32] != 8'hff) begin
            n_steps++;
        end
        cycle_limit = n_steps + 4 + 20;  // trace plus reset plus slack

        repeat (4) @(posedge clk_i);
        #1 reset_i = 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            apply_step(trace_mem[2 * i]);
            drive_payload(i);
            #7;
            check_step(i, trace_mem[2 * i], trace_mem[2 * i + 1]);
            @(posedge clk_i);
            #1;
        end

        if (error_count == 0 && n_steps > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hw/port_map_pkg.sv
hw/addr_chan_if.sv
hw/addr_arbiter.sv
hw/w_channel_router.sv
hw/resp_router.sv
hw/axi_port_merge.sv
bench/merge_props.sv
bench/tb_axi_port_merge.sv

// File: hw/addr_arbiter.sv
/*
 * Round-robin arbiter for one address channel of the three masters.
 * A shown request keeps its grant until the consumer takes it.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module addr_arbiter (
    input  logic                                        clk_i,
    input  logic                                        reset_i,
    input  logic [`MERGE_N_SRC-1:0]                     req_valid_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ID_W-1:0]    req_id_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ADDR_W-1:0]  req_addr_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_LEN_W-1:0]   req_len_i,
    output logic [`MERGE_N_SRC-1:0]                     req_ready_o,
    addr_chan_if.arb                                    out
);

    localparam int unsigned N_SRC = `MERGE_N_SRC;
    localparam int unsigned IDX_W = $clog2(N_SRC);

    logic [IDX_W-1:0] ptr_q;       // first source to look at
    logic             lock_q;
    logic [IDX_W-1:0] lock_idx_q;
    logic [IDX_W-1:0] rr_idx;
    logic             rr_found;
    logic [IDX_W-1:0] grant;
    logic             handshake;

    // --------------------------------------------------
    // pick the first requester at or after the pointer
    // --------------------------------------------------
    always_comb begin
        int unsigned cand;
        rr_idx   = ptr_q;
        rr_found = 1'b0;
        cand     = 0;
        for (int unsigned k = 0; k < N_SRC; k++) begin
            cand = (32'(ptr_q) + k) % N_SRC;
            if (!rr_found && req_valid_i[cand]) begin
                rr_idx   = IDX_W'(cand);
                rr_found = 1'b1;
            end
        end
    end

    assign grant     = lock_q ? lock_idx_q : rr_idx;
    assign out.valid = lock_q ? req_valid_i[lock_idx_q] : rr_found;
    assign out.id    = req_id_i[grant];
    assign out.addr  = req_addr_i[grant];
    assign out.len   = req_len_i[grant];
    assign handshake = out.valid & out.ready;

    always_comb begin
        req_ready_o        = '0;
        req_ready_o[grant] = handshake;  // only the winner sees ready
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q      <= port_map_pkg::SRC_ICACHE;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (handshake) begin
            lock_q <= 1'b0;
            ptr_q  <= (grant == IDX_W'(N_SRC - 1)) ? '0 : grant + 1'b1;
        end else if (out.valid) begin
            lock_q     <= 1'b1;  // stalled, freeze the choice
            lock_idx_q <= grant;
        end
    end

endmodule

// File: hw/addr_chan_if.sv
/*
 * One merged AR or AW channel between an arbiter and its consumer.
 * The write router listens in through the monitor view.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

interface addr_chan_if;

    logic                    valid;
    logic                    ready;
    logic [`MERGE_ID_W-1:0]  id;
    logic [`MERGE_ADDR_W-1:0] addr;
    logic [`MERGE_LEN_W-1:0] len;

    modport arb (output valid, id, addr, len, input ready);

    modport consumer (input valid, id, addr, len, output ready);

    // passive view, sees handshakes only
    modport monitor (input valid, ready, id, addr, len);

endinterface

// File: hw/axi_port_merge.sv
/*
 * Merges the icache, bypass and dcache AXI-style ports into one
 * memory port. Index s of every src_ field belongs to master s.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module axi_port_merge (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    // master side
    input  logic [`MERGE_N_SRC-1:0]                       src_ar_valid_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ID_W-1:0]      src_ar_id_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ADDR_W-1:0]    src_ar_addr_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_LEN_W-1:0]     src_ar_len_i,
    output logic [`MERGE_N_SRC-1:0]                       src_ar_ready_o,
    input  logic [`MERGE_N_SRC-1:0]                       src_aw_valid_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ID_W-1:0]      src_aw_id_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_ADDR_W-1:0]    src_aw_addr_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_LEN_W-1:0]     src_aw_len_i,
    output logic [`MERGE_N_SRC-1:0]                       src_aw_ready_o,
    input  logic [`MERGE_N_SRC-1:0]                       src_w_valid_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_DATA_W-1:0]    src_w_data_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_DATA_W/8-1:0]  src_w_strb_i,
    input  logic [`MERGE_N_SRC-1:0]                       src_w_last_i,
    output logic [`MERGE_N_SRC-1:0]                       src_w_ready_o,
    output logic [`MERGE_N_SRC-1:0]                       src_r_valid_o,
    output logic [`MERGE_N_SRC-1:0][`MERGE_ID_W-1:0]      src_r_id_o,
    output logic [`MERGE_N_SRC-1:0][`MERGE_DATA_W-1:0]    src_r_data_o,
    output logic [`MERGE_N_SRC-1:0][`MERGE_RESP_W-1:0]    src_r_resp_o,
    output logic [`MERGE_N_SRC-1:0]                       src_r_last_o,
    input  logic [`MERGE_N_SRC-1:0]                       src_r_ready_i,
    output logic [`MERGE_N_SRC-1:0]                       src_b_valid_o,
    output logic [`MERGE_N_SRC-1:0][`MERGE_ID_W-1:0]      src_b_id_o,
    output logic [`MERGE_N_SRC-1:0][`MERGE_RESP_W-1:0]    src_b_resp_o,
    input  logic [`MERGE_N_SRC-1:0]                       src_b_ready_i,
    // memory side
    output logic                                          m_ar_valid_o,
    output logic [`MERGE_ID_W-1:0]                        m_ar_id_o,
    output logic [`MERGE_ADDR_W-1:0]                      m_ar_addr_o,
    output logic [`MERGE_LEN_W-1:0]                       m_ar_len_o,
    input  logic                                          m_ar_ready_i,
    output logic                                          m_aw_valid_o,
    output logic [`MERGE_ID_W-1:0]                        m_aw_id_o,
    output logic [`MERGE_ADDR_W-1:0]                      m_aw_addr_o,
    output logic [`MERGE_LEN_W-1:0]                       m_aw_len_o,
    input  logic                                          m_aw_ready_i,
    output logic                                          m_w_valid_o,
    output logic [`MERGE_DATA_W-1:0]                      m_w_data_o,
    output logic [`MERGE_DATA_W/8-1:0]                    m_w_strb_o,
    output logic                                          m_w_last_o,
    input  logic                                          m_w_ready_i,
    input  logic                                          m_r_valid_i,
    input  logic [`MERGE_ID_W-1:0]                        m_r_id_i,
    input  logic [`MERGE_DATA_W-1:0]                      m_r_data_i,
    input  logic [`MERGE_RESP_W-1:0]                      m_r_resp_i,
    input  logic                                          m_r_last_i,
    output logic                                          m_r_ready_o,
    input  logic                                          m_b_valid_i,
    input  logic [`MERGE_ID_W-1:0]                        m_b_id_i,
    input  logic [`MERGE_RESP_W-1:0]                      m_b_resp_i,
    output logic                                          m_b_ready_o
);

    logic w_fifo_full;

    addr_chan_if ar_chan ();
    addr_chan_if aw_chan ();

    // --------------------------------------------------
    // address channels
    // --------------------------------------------------
    addr_arbiter ar_arb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (src_ar_valid_i),
        .req_id_i    (src_ar_id_i),
        .req_addr_i  (src_ar_addr_i),
        .req_len_i   (src_ar_len_i),
        .req_ready_o (src_ar_ready_o),
        .out         (ar_chan)
    );

    addr_arbiter aw_arb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (src_aw_valid_i),
        .req_id_i    (src_aw_id_i),
        .req_addr_i  (src_aw_addr_i),
        .req_len_i   (src_aw_len_i),
        .req_ready_o (src_aw_ready_o),
        .out         (aw_chan)
    );

    assign ar_chan.ready = m_ar_ready_i;
    assign m_ar_valid_o  = ar_chan.valid;
    assign m_ar_id_o     = ar_chan.id;
    assign m_ar_addr_o   = ar_chan.addr;
    assign m_ar_len_o    = ar_chan.len;

    // a full source FIFO holds AW back on both sides of the handshake
    assign aw_chan.ready = m_aw_ready_i & ~w_fifo_full;
    assign m_aw_valid_o  = aw_chan.valid & ~w_fifo_full;
    assign m_aw_id_o     = aw_chan.id;
    assign m_aw_addr_o   = aw_chan.addr;
    assign m_aw_len_o    = aw_chan.len;

    // --------------------------------------------------
    // write data and responses
    // --------------------------------------------------
    w_channel_router w_router (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .aw            (aw_chan),
        .src_w_valid_i (src_w_valid_i),
        .src_w_data_i  (src_w_data_i),
        .src_w_strb_i  (src_w_strb_i),
        .src_w_last_i  (src_w_last_i),
        .src_w_ready_o (src_w_ready_o),
        .m_w_valid_o   (m_w_valid_o),
        .m_w_data_o    (m_w_data_o),
        .m_w_strb_o    (m_w_strb_o),
        .m_w_last_o    (m_w_last_o),
        .m_w_ready_i   (m_w_ready_i),
        .fifo_full_o   (w_fifo_full)
    );

    resp_router r_b_router (
        .m_r_valid_i   (m_r_valid_i),
        .m_r_id_i      (m_r_id_i),
        .m_r_ready_o   (m_r_ready_o),
        .src_r_valid_o (src_r_valid_o),
        .src_r_ready_i (src_r_ready_i),
        .m_b_valid_i   (m_b_valid_i),
        .m_b_id_i      (m_b_id_i),
        .m_b_ready_o   (m_b_ready_o),
        .src_b_valid_o (src_b_valid_o),
        .src_b_ready_i (src_b_ready_i)
    );

    // payload goes to everyone, valid tells who owns it
    assign src_r_id_o   = {`MERGE_N_SRC{m_r_id_i}};
    assign src_r_data_o = {`MERGE_N_SRC{m_r_data_i}};
    assign src_r_resp_o = {`MERGE_N_SRC{m_r_resp_i}};
    assign src_r_last_o = {`MERGE_N_SRC{m_r_last_i}};
    assign src_b_id_o   = {`MERGE_N_SRC{m_b_id_i}};
    assign src_b_resp_o = {`MERGE_N_SRC{m_b_resp_i}};

endmodule

// File: hw/port_map_pkg.sv
/*
 * Source encoding of the merged port's ID.
 * The top two ID bits name the master, the rest is the bypass sub-ID.
 */
`include "merge_params.svh"

package port_map_pkg;

    // source codes carried in id[3:2], code 01 reserved
    localparam logic [1:0] SRC_CODE_ICACHE = 2'b00;
    localparam logic [1:0] SRC_CODE_BYPASS = 2'b10;
    localparam logic [1:0] SRC_CODE_DCACHE = 2'b11;

    // position of each master in the per-source port arrays
    localparam logic [1:0] SRC_ICACHE = 2'd0;
    localparam logic [1:0] SRC_BYPASS = 2'd1;
    localparam logic [1:0] SRC_DCACHE = 2'd2;

    typedef struct packed {
        logic [1:0]              src;  // source code
        logic [`MERGE_ID_W-3:0]  sub;  // bypass sub-ID
    } port_id_fields_t;

    typedef union packed {
        logic [`MERGE_ID_W-1:0] raw;
        port_id_fields_t        fields;
    } port_id_u;

    function automatic logic [1:0] source_of(input logic [1:0] code);
        case (code)
            SRC_CODE_BYPASS: return SRC_BYPASS;
            SRC_CODE_ICACHE: return SRC_ICACHE;
            SRC_CODE_DCACHE: return SRC_DCACHE;
            default:         return SRC_DCACHE;  // reserved code lands on dcache
        endcase
    endfunction

endpackage

// File: hw/resp_router.sv
/*
 * Hands R and B responses back to the master named in the ID.
 * Purely combinational, payload fields are fanned out by the top.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module resp_router (
    input  logic                    m_r_valid_i,
    input  logic [`MERGE_ID_W-1:0]  m_r_id_i,
    output logic                    m_r_ready_o,
    output logic [`MERGE_N_SRC-1:0] src_r_valid_o,
    input  logic [`MERGE_N_SRC-1:0] src_r_ready_i,
    input  logic                    m_b_valid_i,
    input  logic [`MERGE_ID_W-1:0]  m_b_id_i,
    output logic                    m_b_ready_o,
    output logic [`MERGE_N_SRC-1:0] src_b_valid_o,
    input  logic [`MERGE_N_SRC-1:0] src_b_ready_i
);

    port_map_pkg::port_id_u r_id_u;
    port_map_pkg::port_id_u b_id_u;
    logic [1:0]             r_sel;
    logic [1:0]             b_sel;

    // one-hot valid toward the owning master
    function automatic logic [`MERGE_N_SRC-1:0] steer(input logic [1:0] sel,
                                                      input logic       valid);
        logic [`MERGE_N_SRC-1:0] onehot;
        onehot      = '0;
        onehot[sel] = valid;
        return onehot;
    endfunction

    assign r_id_u.raw = m_r_id_i;
    assign b_id_u.raw = m_b_id_i;
    assign r_sel      = port_map_pkg::source_of(r_id_u.fields.src);
    assign b_sel      = port_map_pkg::source_of(b_id_u.fields.src);

    assign src_r_valid_o = steer(r_sel, m_r_valid_i);
    assign m_r_ready_o   = src_r_ready_i[r_sel];  // owner decides

    assign src_b_valid_o = steer(b_sel, m_b_valid_i);
    assign m_b_ready_o   = src_b_ready_i[b_sel];

endmodule

// File: hw/w_channel_router.sv
/*
 * Write data steering for the merged port.
 * Each accepted AW pushes its master index, the FIFO head picks the
 * master whose W beats go out, and the last beat pops the entry.
 */
`timescale 1ns/1ps
`include "merge_params.svh"

module w_channel_router (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    addr_chan_if.monitor                                  aw,
    input  logic [`MERGE_N_SRC-1:0]                       src_w_valid_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_DATA_W-1:0]    src_w_data_i,
    input  logic [`MERGE_N_SRC-1:0][`MERGE_DATA_W/8-1:0]  src_w_strb_i,
    input  logic [`MERGE_N_SRC-1:0]                       src_w_last_i,
    output logic [`MERGE_N_SRC-1:0]                       src_w_ready_o,
    output logic                                          m_w_valid_o,
    output logic [`MERGE_DATA_W-1:0]                      m_w_data_o,
    output logic [`MERGE_DATA_W/8-1:0]                    m_w_strb_o,
    output logic                                          m_w_last_o,
    input  logic                                          m_w_ready_i,
    output logic                                          fifo_full_o
);

    localparam int unsigned DEPTH = `MERGE_W_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [1:0]             src_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [CNT_W-1:0]       count_q;
    port_map_pkg::port_id_u aw_id_u;
    logic [1:0]             push_src;
    logic [1:0]             head_src;
    logic                   push;
    logic                   pop;
    logic                   empty;

    // --------------------------------------------------
    // source FIFO, registered so no beat passes with AW
    // --------------------------------------------------
    assign aw_id_u.raw = aw.id;
    assign push_src    = port_map_pkg::source_of(aw_id_u.fields.src);
    assign push        = aw.valid & aw.ready;
    assign pop         = m_w_valid_o & m_w_ready_i & m_w_last_o;  // burst done
    assign empty       = (count_q == '0);
    assign fifo_full_o = (count_q == CNT_W'(DEPTH));
    assign head_src    = src_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            src_mem[wr_ptr_q] <= push_src;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // --------------------------------------------------
    // W mux, closed while nothing is outstanding
    // --------------------------------------------------
    assign m_w_valid_o = ~empty & src_w_valid_i[head_src];
    assign m_w_data_o  = src_w_data_i[head_src];
    assign m_w_strb_o  = src_w_strb_i[head_src];
    assign m_w_last_o  = src_w_last_i[head_src];

    always_comb begin
        src_w_ready_o           = '0;
        src_w_ready_o[head_src] = ~empty & m_w_ready_i;
    end

endmodule

// File: include/merge_params.svh
/*
 * Width and depth settings for the memory-side port merge.
 * Include wherever a bus field or the write-source FIFO is sized.
 */
`ifndef MERGE_PARAMS_SVH
`define MERGE_PARAMS_SVH

`define MERGE_ADDR_W  32
`define MERGE_DATA_W  64   // strb is MERGE_DATA_W/8
`define MERGE_ID_W    4
`define MERGE_LEN_W   8
`define MERGE_RESP_W  2

// icache, bypass, dcache
`define MERGE_N_SRC   3

// one more than the blocking masters can keep in flight
`define MERGE_W_DEPTH 4

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the port merge testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f compile.f --top-module tb_axi_port_merge -o sim_merge

./obj_dir/sim_merge > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0
